// File: logic/radio_defs.svh
/* register map, counts and widths of the radio core
   settings and readback addresses are 8 bits, offsets are relative to their base */

`ifndef RADIO_DEFS_SVH
`define RADIO_DEFS_SVH

// ------------------------------
// counts and widths
// ------------------------------
`define RADIO_NUM_DBOARDS        2
`define RADIO_CHANS_PER_DB       2
`define RADIO_FP_GPIO_WIDTH      12
`define RADIO_SET_ADDR_WIDTH     8
`define RADIO_SET_DATA_WIDTH     32
`define RADIO_RB_DATA_WIDTH      64
`define RADIO_GPIO_WIDTH         32
`define RADIO_LED_WIDTH          3
`define RADIO_SAMPLE_WIDTH       32

// ------------------------------
// settings register map
// ------------------------------
`define RADIO_SR_DB_BASE         160
`define RADIO_SR_RX_FE_BASE      224   // db base + 64
`define RADIO_SR_FE_CHAN_OFFSET  16

`define RADIO_SR_MISC_OUT        0
`define RADIO_SR_LEDS            1
`define RADIO_SR_FP_GPIO_OUT     2
`define RADIO_SR_FP_GPIO_DDR     3
`define RADIO_SR_DB_GPIO_OUT     4
`define RADIO_SR_DB_GPIO_DDR     5

// readback map
`define RADIO_RB_DB_BASE         16
`define RADIO_RB_MISC            0
`define RADIO_RB_DB_GPIO         1
`define RADIO_RB_FP_GPIO         2

// front-end config bits
`define RADIO_FE_SWAP_IQ         0
`define RADIO_FE_NEGATE_Q        1

`endif

// File: logic/settings_bus_pkg.sv
/* types of the settings write bus, the readback bus and the gpio words
   all are plain unsigned vectors */

`include "radio_defs.svh"

package settings_bus_pkg;

   // settings write
   typedef logic [`RADIO_SET_ADDR_WIDTH-1:0] set_addr_t;
   typedef logic [`RADIO_SET_DATA_WIDTH-1:0] set_data_t;

   // readback word, {upper: input side, lower: register side}
   typedef logic [`RADIO_RB_DATA_WIDTH-1:0]  rb_data_t;

   // gpio and misc
   typedef logic [`RADIO_GPIO_WIDTH-1:0]     gpio_word_t;
   typedef logic [`RADIO_FP_GPIO_WIDTH-1:0]  fp_gpio_t;
   typedef logic [`RADIO_LED_WIDTH-1:0]      led_t;   // {rx, txrx_tx, txrx_rx}

endpackage

// File: logic/sample_pkg.sv
/* radio sample types
   a sample packs I in the upper half and Q in the lower half, both signed */

`include "radio_defs.svh"

package sample_pkg;

   typedef logic [`RADIO_SAMPLE_WIDTH-1:0] sample_t;   // {i, q}

   // one I or Q component
   typedef logic signed [`RADIO_SAMPLE_WIDTH/2-1:0] iq_t;

   // front-end config
   // bit 0 swaps I and Q, bit 1 negates Q
   typedef logic [1:0] fe_cfg_t;

endpackage

// File: logic/db_control.sv
/* one daughterboard register bank with its readback port
   writes land one cycle after i_set_stb, readback answers one cycle after i_rb_stb
   unknown write addresses are ignored, unknown readback addresses return zero */

`include "radio_defs.svh"

module db_control (
   input  logic                         radio_clk,
   input  logic                         i_reset,
   // settings write
   input  logic                         i_set_stb,
   input  settings_bus_pkg::set_addr_t  i_set_addr,
   input  settings_bus_pkg::set_data_t  i_set_data,
   // readback
   input  logic                         i_rb_stb,
   input  settings_bus_pkg::set_addr_t  i_rb_addr,
   output logic                         o_rb_stb,
   output settings_bus_pkg::rb_data_t   o_rb_data,
   // board i/o
   input  settings_bus_pkg::gpio_word_t i_misc_in,
   input  settings_bus_pkg::gpio_word_t i_db_gpio_in,
   input  settings_bus_pkg::gpio_word_t i_fp_gpio_in,
   output settings_bus_pkg::gpio_word_t o_misc_out,
   output settings_bus_pkg::gpio_word_t o_db_gpio_out,
   output settings_bus_pkg::gpio_word_t o_db_gpio_ddr,
   output settings_bus_pkg::fp_gpio_t   o_fp_gpio_out,
   output settings_bus_pkg::fp_gpio_t   o_fp_gpio_ddr,
   output settings_bus_pkg::led_t       o_leds
);

   // absolute write addresses
   localparam settings_bus_pkg::set_addr_t ADDR_MISC_OUT =
      settings_bus_pkg::set_addr_t'(`RADIO_SR_DB_BASE + `RADIO_SR_MISC_OUT);
   localparam settings_bus_pkg::set_addr_t ADDR_LEDS =
      settings_bus_pkg::set_addr_t'(`RADIO_SR_DB_BASE + `RADIO_SR_LEDS);
   localparam settings_bus_pkg::set_addr_t ADDR_FP_OUT =
      settings_bus_pkg::set_addr_t'(`RADIO_SR_DB_BASE + `RADIO_SR_FP_GPIO_OUT);
   localparam settings_bus_pkg::set_addr_t ADDR_FP_DDR =
      settings_bus_pkg::set_addr_t'(`RADIO_SR_DB_BASE + `RADIO_SR_FP_GPIO_DDR);
   localparam settings_bus_pkg::set_addr_t ADDR_DB_OUT =
      settings_bus_pkg::set_addr_t'(`RADIO_SR_DB_BASE + `RADIO_SR_DB_GPIO_OUT);
   localparam settings_bus_pkg::set_addr_t ADDR_DB_DDR =
      settings_bus_pkg::set_addr_t'(`RADIO_SR_DB_BASE + `RADIO_SR_DB_GPIO_DDR);

   // absolute readback addresses
   localparam settings_bus_pkg::set_addr_t RB_MISC =
      settings_bus_pkg::set_addr_t'(`RADIO_RB_DB_BASE + `RADIO_RB_MISC);
   localparam settings_bus_pkg::set_addr_t RB_DB_GPIO =
      settings_bus_pkg::set_addr_t'(`RADIO_RB_DB_BASE + `RADIO_RB_DB_GPIO);
   localparam settings_bus_pkg::set_addr_t RB_FP_GPIO =
      settings_bus_pkg::set_addr_t'(`RADIO_RB_DB_BASE + `RADIO_RB_FP_GPIO);

   // ------------------------------
   // register bank
   // ------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_misc_out    <= '0;
         o_leds        <= '0;
         o_fp_gpio_out <= '0;
         o_fp_gpio_ddr <= '0;
         o_db_gpio_out <= '0;
         o_db_gpio_ddr <= '0;
      end else if (i_set_stb) begin
         case (i_set_addr)
            ADDR_MISC_OUT: o_misc_out    <= i_set_data;
            ADDR_LEDS:     o_leds        <= i_set_data[`RADIO_LED_WIDTH-1:0];
            ADDR_FP_OUT:   o_fp_gpio_out <= i_set_data[`RADIO_FP_GPIO_WIDTH-1:0];
            ADDR_FP_DDR:   o_fp_gpio_ddr <= i_set_data[`RADIO_FP_GPIO_WIDTH-1:0];
            ADDR_DB_OUT:   o_db_gpio_out <= i_set_data;
            ADDR_DB_DDR:   o_db_gpio_ddr <= i_set_data;
            default: ;     // not ours, e.g. front-end addresses
         endcase
      end
   end

   // ------------------------------
   // readback
   // ------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_rb_stb  <= 1'b0;
         o_rb_data <= '0;
      end else begin
         o_rb_stb <= i_rb_stb;
         if (i_rb_stb) begin   // data holds until the next read
            case (i_rb_addr)
               RB_MISC:    o_rb_data <= {i_misc_in, o_misc_out};
               RB_DB_GPIO: o_rb_data <= {i_db_gpio_in, o_db_gpio_out};
               RB_FP_GPIO: o_rb_data <= {i_fp_gpio_in,
                                         settings_bus_pkg::gpio_word_t'(o_fp_gpio_out)};
               default:    o_rb_data <= '0;
            endcase
         end
      end
   end

endmodule

// File: logic/rx_frontend.sv
/* receive correction for the channels of one daughterboard
   one cycle from i_rx_stb to o_rx_stb, a sample can enter every cycle
   Q negation saturates, the swap is applied after the negation */

`include "radio_defs.svh"

module rx_frontend (
   input  logic                                             radio_clk,
   input  logic                                             i_reset,
   // settings write
   input  logic                                             i_set_stb,
   input  settings_bus_pkg::set_addr_t                      i_set_addr,
   input  settings_bus_pkg::set_data_t                      i_set_data,
   // samples, one per channel
   input  logic [`RADIO_CHANS_PER_DB-1:0]                   i_rx_stb,
   input  sample_pkg::sample_t [`RADIO_CHANS_PER_DB-1:0]    i_rx_data,
   output logic [`RADIO_CHANS_PER_DB-1:0]                   o_rx_stb,
   output sample_pkg::sample_t [`RADIO_CHANS_PER_DB-1:0]    o_rx_data
);

   localparam int NUM_CHANS = `RADIO_CHANS_PER_DB;

   sample_pkg::fe_cfg_t cfg [NUM_CHANS];   // per-channel config register

   // correct one sample under one config
   function automatic sample_pkg::sample_t correct(input sample_pkg::sample_t s,
                                                   input sample_pkg::fe_cfg_t c);
      sample_pkg::iq_t i_comp;
      sample_pkg::iq_t q_comp;
      i_comp = s[`RADIO_SAMPLE_WIDTH-1:`RADIO_SAMPLE_WIDTH/2];
      q_comp = s[`RADIO_SAMPLE_WIDTH/2-1:0];
      if (c[`RADIO_FE_NEGATE_Q]) begin
         // -32768 has no positive twin, clamp it
         if (q_comp == 16'sh8000)
            q_comp = 16'sh7fff;
         else
            q_comp = -q_comp;
      end
      if (c[`RADIO_FE_SWAP_IQ])
         return {q_comp, i_comp};
      return {i_comp, q_comp};
   endfunction

   // ------------------------------
   // config writes
   // ------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         for (int c = 0; c < NUM_CHANS; c++)
            cfg[c] <= '0;
      end else if (i_set_stb) begin
         for (int c = 0; c < NUM_CHANS; c++) begin
            if (i_set_addr == settings_bus_pkg::set_addr_t'(`RADIO_SR_RX_FE_BASE +
                                                            c * `RADIO_SR_FE_CHAN_OFFSET))
               cfg[c] <= i_set_data[1:0];
         end
      end
   end

   // ------------------------------
   // sample path
   // ------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_rx_stb  <= '0;
         o_rx_data <= '0;
      end else begin
         o_rx_stb <= i_rx_stb;   // fixed one-cycle latency
         for (int c = 0; c < NUM_CHANS; c++) begin
            if (i_rx_stb[c])
               o_rx_data[c] <= correct(i_rx_data[c], cfg[c]);
         end
      end
   end

endmodule

// File: logic/x300_radio_core.sv
/* radio-clock part of the core: two daughterboard banks and two receive front ends
   each radio's ADC word feeds both channels of its board
   misc and front-panel outputs pass one extra register, front-panel comes from board 0 */

`include "radio_defs.svh"

module x300_radio_core (
   input  logic                                 radio_clk,
   input  logic                                 i_reset,
   // settings and readback
   input  logic [`RADIO_NUM_DBOARDS-1:0]        i_set_stb,
   input  settings_bus_pkg::set_addr_t          i_set_addr,
   input  settings_bus_pkg::set_data_t          i_set_data,
   input  logic [`RADIO_NUM_DBOARDS-1:0]        i_rb_stb,
   input  settings_bus_pkg::set_addr_t          i_rb_addr,
   output logic [`RADIO_NUM_DBOARDS-1:0]        o_rb_stb,
   output settings_bus_pkg::rb_data_t           o_rb_data0,
   output settings_bus_pkg::rb_data_t           o_rb_data1,
   // samples
   input  sample_pkg::sample_t                  i_rx0,
   input  sample_pkg::sample_t                  i_rx1,
   input  logic [`RADIO_NUM_DBOARDS-1:0]        i_rx_stb,
   output sample_pkg::sample_t                  o_rx_ch0,
   output sample_pkg::sample_t                  o_rx_ch1,
   output sample_pkg::sample_t                  o_rx_ch2,
   output sample_pkg::sample_t                  o_rx_ch3,
   output logic [`RADIO_NUM_DBOARDS*`RADIO_CHANS_PER_DB-1:0] o_rx_stb,
   // gpio, leds, misc
   input  settings_bus_pkg::gpio_word_t         i_db0_gpio_in,
   input  settings_bus_pkg::gpio_word_t         i_db1_gpio_in,
   input  settings_bus_pkg::gpio_word_t         i_fp_gpio_in,
   input  settings_bus_pkg::gpio_word_t         i_radio0_misc_in,
   input  settings_bus_pkg::gpio_word_t         i_radio1_misc_in,
   output settings_bus_pkg::gpio_word_t         o_db0_gpio_out,
   output settings_bus_pkg::gpio_word_t         o_db0_gpio_ddr,
   output settings_bus_pkg::gpio_word_t         o_db1_gpio_out,
   output settings_bus_pkg::gpio_word_t         o_db1_gpio_ddr,
   output settings_bus_pkg::fp_gpio_t           o_fp_gpio_out,
   output settings_bus_pkg::fp_gpio_t           o_fp_gpio_ddr,
   output settings_bus_pkg::led_t               o_radio_led0,
   output settings_bus_pkg::led_t               o_radio_led1,
   output settings_bus_pkg::gpio_word_t         o_radio0_misc_out,
   output settings_bus_pkg::gpio_word_t         o_radio1_misc_out
);

   localparam int NUM_DB = `RADIO_NUM_DBOARDS;

   // per-board wiring
   settings_bus_pkg::gpio_word_t misc_in_r   [NUM_DB];   // sampled misc inputs
   settings_bus_pkg::gpio_word_t misc_out    [NUM_DB];
   settings_bus_pkg::gpio_word_t db_gpio_in  [NUM_DB];
   settings_bus_pkg::gpio_word_t db_gpio_out [NUM_DB];
   settings_bus_pkg::gpio_word_t db_gpio_ddr [NUM_DB];
   settings_bus_pkg::fp_gpio_t   fp_out      [NUM_DB];
   settings_bus_pkg::fp_gpio_t   fp_ddr      [NUM_DB];
   settings_bus_pkg::led_t       leds        [NUM_DB];
   settings_bus_pkg::rb_data_t   rb_data     [NUM_DB];
   logic                         rb_stb      [NUM_DB];
   sample_pkg::sample_t          radio_rx    [NUM_DB];
   logic [`RADIO_CHANS_PER_DB-1:0]                fe_stb  [NUM_DB];
   sample_pkg::sample_t [`RADIO_CHANS_PER_DB-1:0] fe_data [NUM_DB];

   assign db_gpio_in[0] = i_db0_gpio_in;
   assign db_gpio_in[1] = i_db1_gpio_in;
   assign radio_rx[0]   = i_rx0;
   assign radio_rx[1]   = i_rx1;

   // ------------------------------
   // per-board instances
   // ------------------------------
   for (genvar b = 0; b < NUM_DB; b++) begin : g_board
      db_control u_db_control (
         .radio_clk     (radio_clk),
         .i_reset       (i_reset),
         .i_set_stb     (i_set_stb[b]),
         .i_set_addr    (i_set_addr),
         .i_set_data    (i_set_data),
         .i_rb_stb      (i_rb_stb[b]),
         .i_rb_addr     (i_rb_addr),
         .o_rb_stb      (rb_stb[b]),
         .o_rb_data     (rb_data[b]),
         .i_misc_in     (misc_in_r[b]),
         .i_db_gpio_in  (db_gpio_in[b]),
         .i_fp_gpio_in  (i_fp_gpio_in),   // fp inputs go to every board
         .o_misc_out    (misc_out[b]),
         .o_db_gpio_out (db_gpio_out[b]),
         .o_db_gpio_ddr (db_gpio_ddr[b]),
         .o_fp_gpio_out (fp_out[b]),
         .o_fp_gpio_ddr (fp_ddr[b]),
         .o_leds        (leds[b])
      );

      rx_frontend u_rx_frontend (
         .radio_clk  (radio_clk),
         .i_reset    (i_reset),
         .i_set_stb  (i_set_stb[b]),
         .i_set_addr (i_set_addr),
         .i_set_data (i_set_data),
         .i_rx_stb   ({`RADIO_CHANS_PER_DB{i_rx_stb[b]}}),
         .i_rx_data  ({`RADIO_CHANS_PER_DB{radio_rx[b]}}),   // same adc word on both chans
         .o_rx_stb   (fe_stb[b]),
         .o_rx_data  (fe_data[b])
      );
   end

   // ------------------------------
   // channel and i/o mapping
   // ------------------------------
   assign o_rx_ch0 = fe_data[0][0];
   assign o_rx_ch1 = fe_data[0][1];
   assign o_rx_ch2 = fe_data[1][0];
   assign o_rx_ch3 = fe_data[1][1];
   assign o_rx_stb = {fe_stb[1], fe_stb[0]};

   assign o_rb_stb   = {rb_stb[1], rb_stb[0]};
   assign o_rb_data0 = rb_data[0];
   assign o_rb_data1 = rb_data[1];

   assign o_db0_gpio_out = db_gpio_out[0];
   assign o_db0_gpio_ddr = db_gpio_ddr[0];
   assign o_db1_gpio_out = db_gpio_out[1];
   assign o_db1_gpio_ddr = db_gpio_ddr[1];
   assign o_radio_led0   = leds[0];
   assign o_radio_led1   = leds[1];

   // misc and front-panel registers, one cycle behind the banks
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_radio0_misc_out <= '0;
         o_radio1_misc_out <= '0;
         o_fp_gpio_out     <= '0;
         o_fp_gpio_ddr     <= '0;
         misc_in_r[0]      <= '0;
         misc_in_r[1]      <= '0;
      end else begin
         o_radio0_misc_out <= misc_out[0];
         o_radio1_misc_out <= misc_out[1];
         o_fp_gpio_out     <= fp_out[0];   // board 0 owns the front panel
         o_fp_gpio_ddr     <= fp_ddr[0];
         misc_in_r[0]      <= i_radio0_misc_in;
         misc_in_r[1]      <= i_radio1_misc_in;
      end
   end

endmodule

// File: verification/radio_checker.sv
/* compares one DUT output with its expected value per check strobe
   the output is sampled at the rising edge after the strobe is raised */

module radio_checker (
   input  logic        radio_clk,
   input  logic        i_chk_stb,
   input  logic [3:0]  i_chk_sig,
   input  logic [63:0] i_chk_exp,
   input  settings_bus_pkg::rb_data_t   i_rb_data0, i_rb_data1,
   input  sample_pkg::sample_t          i_rx_ch0, i_rx_ch1, i_rx_ch2, i_rx_ch3,
   input  settings_bus_pkg::gpio_word_t i_db0_gpio_out, i_db0_gpio_ddr,
   input  settings_bus_pkg::gpio_word_t i_db1_gpio_out, i_db1_gpio_ddr,
   input  settings_bus_pkg::fp_gpio_t   i_fp_gpio_out, i_fp_gpio_ddr,
   input  settings_bus_pkg::led_t       i_led0, i_led1,
   input  settings_bus_pkg::gpio_word_t i_misc0, i_misc1,
   output int          o_pass_count,
   output int          o_fail_count
);

   initial begin
      o_pass_count = 0;
      o_fail_count = 0;
   end

   function automatic string sig_name(input logic [3:0] id);
      case (id)
         0: return "o_rb_data0";         1: return "o_rb_data1";
         2: return "o_rx_ch0";           3: return "o_rx_ch1";
         4: return "o_rx_ch2";           5: return "o_rx_ch3";
         6: return "o_db0_gpio_out";     7: return "o_db0_gpio_ddr";
         8: return "o_db1_gpio_out";     9: return "o_db1_gpio_ddr";
         10: return "o_fp_gpio_out";     11: return "o_fp_gpio_ddr";
         12: return "o_radio_led0";      13: return "o_radio_led1";
         14: return "o_radio0_misc_out";
         default: return "o_radio1_misc_out";
      endcase
   endfunction

   // zero-extended view of the selected output
   function automatic logic [63:0] actual(input logic [3:0] id);
      case (id)
         0: return i_rb_data0;       1: return i_rb_data1;
         2: return 64'(i_rx_ch0);    3: return 64'(i_rx_ch1);
         4: return 64'(i_rx_ch2);    5: return 64'(i_rx_ch3);
         6: return 64'(i_db0_gpio_out);
         7: return 64'(i_db0_gpio_ddr);
         8: return 64'(i_db1_gpio_out);
         9: return 64'(i_db1_gpio_ddr);
         10: return 64'(i_fp_gpio_out);
         11: return 64'(i_fp_gpio_ddr);
         12: return 64'(i_led0);     13: return 64'(i_led1);
         14: return 64'(i_misc0);
         default: return 64'(i_misc1);
      endcase
   endfunction

   always @(posedge radio_clk) begin
      if (i_chk_stb) begin
         if (actual(i_chk_sig) === i_chk_exp) begin
            o_pass_count <= o_pass_count + 1;
            $display("ok   test %0d: %s = %h", o_pass_count + o_fail_count + 1,
                     sig_name(i_chk_sig), i_chk_exp);
         end else begin
            o_fail_count <= o_fail_count + 1;
            $display("** Error at %0t: %s expected %h, got %h", $time,
                     sig_name(i_chk_sig), i_chk_exp, actual(i_chk_sig));
         end
      end
   end

endmodule

// File: verification/radio_core_props.sv
/* strobe timing rules of the radio core, bound to every x300_radio_core instance */

module radio_core_props (
   input logic       radio_clk,
   input logic       i_reset,
   input logic [1:0] i_rb_stb,
   input logic [1:0] o_rb_stb,
   input logic [1:0] i_rx_stb,
   input logic [3:0] o_rx_stb
);

   a_rb_follows: assert property (@(posedge radio_clk) disable iff (i_reset)
      !$past(i_reset) |-> o_rb_stb == $past(i_rb_stb))
      else $error("o_rb_stb does not follow i_rb_stb by one cycle");

   // each radio feeds two channels
   a_rx_follows: assert property (@(posedge radio_clk) disable iff (i_reset)
      !$past(i_reset) |->
         o_rx_stb == {{2{$past(i_rx_stb[1])}}, {2{$past(i_rx_stb[0])}}})
      else $error("o_rx_stb does not follow i_rx_stb by one cycle");

   a_reset_quiet: assert property (@(posedge radio_clk)
      $past(i_reset) |-> (o_rb_stb == '0 && o_rx_stb == '0))
      else $error("strobe output high during reset");

endmodule

bind x300_radio_core radio_core_props u_radio_core_props (.*);

// File: verification/tb_x300_radio_core.sv
/* testbench of the radio core, table driven, inputs change on the falling edge
   misc and front-panel outputs are checked two cycles after the write */

`include "radio_defs.svh"

module tb_x300_radio_core;

   localparam int MAX_ENTRIES = 56;
   localparam int TIMEOUT     = 10;   // cycles per strobe wait
   // entry kinds
   localparam logic [2:0] K_WRITE = 0, K_READ = 1, K_SAMPLE = 2, K_PAIR = 3;
   localparam logic [2:0] K_CHECK = 4, K_SETIN = 5;
   localparam int DB = `RADIO_SR_DB_BASE;
   localparam int RB = `RADIO_RB_DB_BASE;
   localparam int FE = `RADIO_SR_RX_FE_BASE;

   logic radio_clk = 1'b0;
   logic i_reset;
   logic [1:0] i_set_stb, i_rb_stb, i_rx_stb, o_rb_stb;
   logic [3:0] o_rx_stb;
   settings_bus_pkg::set_addr_t i_set_addr, i_rb_addr;
   settings_bus_pkg::set_data_t i_set_data;
   settings_bus_pkg::rb_data_t  o_rb_data0, o_rb_data1;
   sample_pkg::sample_t i_rx0, i_rx1, o_rx_ch0, o_rx_ch1, o_rx_ch2, o_rx_ch3;
   settings_bus_pkg::gpio_word_t i_db0_gpio_in, i_db1_gpio_in, i_fp_gpio_in;
   settings_bus_pkg::gpio_word_t i_radio0_misc_in, i_radio1_misc_in;
   settings_bus_pkg::gpio_word_t o_db0_gpio_out, o_db0_gpio_ddr, o_db1_gpio_out;
   settings_bus_pkg::gpio_word_t o_db1_gpio_ddr, o_radio0_misc_out, o_radio1_misc_out;
   settings_bus_pkg::fp_gpio_t   o_fp_gpio_out, o_fp_gpio_ddr;
   settings_bus_pkg::led_t       o_radio_led0, o_radio_led1;

   // checker handshake
   logic        chk_stb;
   logic [3:0]  chk_sig;
   logic [63:0] chk_exp;
   int          pass_count, fail_count, timeouts, n_entries;

   // stimulus table
   logic [2:0]  t_kind [MAX_ENTRIES];
   int          t_board[MAX_ENTRIES];
   int          t_addr [MAX_ENTRIES];
   logic [31:0] t_data [MAX_ENTRIES], t_data2[MAX_ENTRIES];
   logic [3:0]  t_sig  [MAX_ENTRIES];
   logic [63:0] t_exp  [MAX_ENTRIES], t_exp2 [MAX_ENTRIES];

   always #50 radio_clk = ~radio_clk;

   x300_radio_core u_x300_radio_core (.*);

   radio_checker u_radio_checker (
      .radio_clk (radio_clk), .i_chk_stb (chk_stb), .i_chk_sig (chk_sig),
      .i_chk_exp (chk_exp), .i_rb_data0 (o_rb_data0), .i_rb_data1 (o_rb_data1),
      .i_rx_ch0 (o_rx_ch0), .i_rx_ch1 (o_rx_ch1), .i_rx_ch2 (o_rx_ch2),
      .i_rx_ch3 (o_rx_ch3), .i_db0_gpio_out (o_db0_gpio_out),
      .i_db0_gpio_ddr (o_db0_gpio_ddr), .i_db1_gpio_out (o_db1_gpio_out),
      .i_db1_gpio_ddr (o_db1_gpio_ddr), .i_fp_gpio_out (o_fp_gpio_out),
      .i_fp_gpio_ddr (o_fp_gpio_ddr), .i_led0 (o_radio_led0), .i_led1 (o_radio_led1),
      .i_misc0 (o_radio0_misc_out), .i_misc1 (o_radio1_misc_out),
      .o_pass_count (pass_count), .o_fail_count (fail_count)
   );

   task automatic add(input logic [2:0] kind, input int board, input int addr,
                      input logic [31:0] data, input logic [31:0] data2,
                      input logic [3:0] sig, input logic [63:0] exp,
                      input logic [63:0] exp2);
      t_kind[n_entries]  = kind;
      t_board[n_entries] = board;
      t_addr[n_entries]  = addr;
      t_data[n_entries]  = data;
      t_data2[n_entries] = data2;
      t_sig[n_entries]   = sig;
      t_exp[n_entries]   = exp;
      t_exp2[n_entries]  = exp2;
      n_entries++;
   endtask

   // hands one expected value to the checker and returns on the next falling edge
   task automatic request_check(input logic [3:0] sig, input logic [63:0] exp);
      chk_sig = sig;
      chk_exp = exp;
      chk_stb = 1'b1;
      @(negedge radio_clk);
      chk_stb = 1'b0;
   endtask

   task automatic wait_rb_strobe(input int b);
      int n;
      n = 0;
      while (!o_rb_stb[b] && n < TIMEOUT) begin
         @(negedge radio_clk);
         n++;
      end
      if (!o_rb_stb[b]) begin
         $display("timeout: board %0d never answered a readback", b);
         timeouts++;
      end
   endtask

   task automatic wait_rx_strobe(input int ch);
      int n;
      n = 0;
      while (!o_rx_stb[ch] && n < TIMEOUT) begin
         @(negedge radio_clk);
         n++;
      end
      if (!o_rx_stb[ch]) begin
         $display("timeout: channel %0d produced no sample", ch);
         timeouts++;
      end
   endtask

   task automatic drive_sample(input int b, input logic [31:0] s);
      if (b == 0) i_rx0 = s;
      else        i_rx1 = s;
      i_rx_stb[b] = 1'b1;
   endtask

   task automatic apply_entry(input int e);
      int b;
      b = t_board[e];
      case (t_kind[e])
         K_WRITE: begin
            i_set_stb[b] = 1'b1;
            i_set_addr   = t_addr[e];
            i_set_data   = t_data[e];
            @(negedge radio_clk);
            i_set_stb = '0;
            if (t_sig[e] inside {10, 11, 14, 15})
               @(negedge radio_clk);   // extra top register
            request_check(t_sig[e], t_exp[e]);
         end
         K_READ: begin
            i_rb_stb[b] = 1'b1;
            i_rb_addr   = t_addr[e];
            @(negedge radio_clk);
            i_rb_stb = '0;
            wait_rb_strobe(b);
            request_check(t_sig[e], t_exp[e]);
         end
         K_SAMPLE, K_PAIR: begin
            drive_sample(b, t_data[e]);
            @(negedge radio_clk);
            if (t_kind[e] == K_PAIR)
               drive_sample(b, t_data2[e]);   // next one right behind
            else
               i_rx_stb = '0;
            wait_rx_strobe(t_sig[e] - 2);
            request_check(t_sig[e], t_exp[e]);
            i_rx_stb = '0;
            if (t_kind[e] == K_PAIR) begin
               wait_rx_strobe(t_sig[e] - 2);
               request_check(t_sig[e], t_exp2[e]);
            end
         end
         K_CHECK: request_check(t_sig[e], t_exp[e]);
         K_SETIN: begin
            case (b)
               0: i_radio0_misc_in = t_data[e];
               1: i_radio1_misc_in = t_data[e];
               2: i_db0_gpio_in    = t_data[e];
               3: i_db1_gpio_in    = t_data[e];
               default: i_fp_gpio_in = t_data[e];
            endcase
            repeat (2) @(negedge radio_clk);
         end
         default: ;
      endcase
   endtask

   // ------------------------------
   // table and run
   // ------------------------------
   initial begin
      i_reset          = 1'b1;
      i_set_stb        = '0;
      i_rb_stb         = '0;
      i_rx_stb         = '0;
      i_set_addr       = '0;
      i_set_data       = '0;
      i_rb_addr        = '0;
      i_rx0            = '0;
      i_rx1            = '0;
      i_db0_gpio_in    = '0;
      i_db1_gpio_in    = '0;
      i_fp_gpio_in     = '0;
      i_radio0_misc_in = '0;
      i_radio1_misc_in = '0;
      chk_stb          = 1'b0;
      chk_sig          = '0;
      chk_exp          = '0;
      timeouts         = 0;
      n_entries        = 0;

      // reset values
      add(K_CHECK, 0, 0, 0, 0, 14, 0, 0);
      add(K_CHECK, 0, 0, 0, 0, 15, 0, 0);
      add(K_CHECK, 0, 0, 0, 0, 6, 0, 0);
      add(K_CHECK, 0, 0, 0, 0, 9, 0, 0);
      add(K_CHECK, 0, 0, 0, 0, 12, 0, 0);
      add(K_CHECK, 0, 0, 0, 0, 10, 0, 0);
      add(K_READ, 0, RB, 0, 0, 0, 0, 0);
      add(K_READ, 1, RB, 0, 0, 1, 0, 0);
      // register writes, each board on its own outputs
      add(K_WRITE, 0, DB + 4, 32'hA5A5_0001, 0, 6, 64'hA5A5_0001, 0);
      add(K_WRITE, 0, DB + 5, 32'h0000_FFFF, 0, 7, 64'h0000_FFFF, 0);
      add(K_CHECK, 0, 0, 0, 0, 8, 0, 0);
      add(K_WRITE, 1, DB + 4, 32'h1234_5678, 0, 8, 64'h1234_5678, 0);
      add(K_CHECK, 0, 0, 0, 0, 6, 64'hA5A5_0001, 0);
      add(K_WRITE, 1, DB + 5, 32'h00FF_00FF, 0, 9, 64'h00FF_00FF, 0);
      add(K_CHECK, 0, 0, 0, 0, 7, 64'h0000_FFFF, 0);
      add(K_WRITE, 0, DB + 1, 32'hFFFF_FFFD, 0, 12, 64'h5, 0);
      add(K_CHECK, 0, 0, 0, 0, 13, 0, 0);
      add(K_WRITE, 1, DB + 1, 32'h0000_0002, 0, 13, 64'h2, 0);
      add(K_WRITE, 0, DB + 2, 32'hABCD_E123, 0, 10, 64'h123, 0);
      add(K_WRITE, 0, DB + 3, 32'h0000_0F0F, 0, 11, 64'hF0F, 0);
      add(K_WRITE, 1, DB + 2, 32'h0000_0777, 0, 10, 64'h123, 0);   // board 1 not on fp
      add(K_WRITE, 0, DB + 0, 32'hDEAD_BEEF, 0, 14, 64'hDEAD_BEEF, 0);
      add(K_WRITE, 1, DB + 0, 32'hCAFE_0001, 0, 15, 64'hCAFE_0001, 0);
      add(K_CHECK, 0, 0, 0, 0, 14, 64'hDEAD_BEEF, 0);
      // readback
      add(K_SETIN, 0, 0, 32'h1357_9BDF, 0, 0, 0, 0);
      add(K_SETIN, 1, 0, 32'h2468_ACE0, 0, 0, 0, 0);
      add(K_SETIN, 2, 0, 32'h0F0F_0F0F, 0, 0, 0, 0);
      add(K_SETIN, 3, 0, 32'h8421_0C0C, 0, 0, 0, 0);
      add(K_SETIN, 4, 0, 32'h0000_0ABC, 0, 0, 0, 0);
      add(K_READ, 0, RB + 0, 0, 0, 0, 64'h1357_9BDF_DEAD_BEEF, 0);
      add(K_READ, 1, RB + 0, 0, 0, 1, 64'h2468_ACE0_CAFE_0001, 0);
      add(K_READ, 0, RB + 1, 0, 0, 0, 64'h0F0F_0F0F_A5A5_0001, 0);
      add(K_READ, 1, RB + 1, 0, 0, 1, 64'h8421_0C0C_1234_5678, 0);
      add(K_READ, 0, RB + 2, 0, 0, 0, 64'h0000_0ABC_0000_0123, 0);
      add(K_READ, 1, RB + 2, 0, 0, 1, 64'h0000_0ABC_0000_0777, 0);
      add(K_READ, 0, RB + 3, 0, 0, 0, 0, 0);   // unmapped
      // default sample path
      add(K_SAMPLE, 0, 0, 32'h1234_ABCD, 0, 2, 64'h1234_ABCD, 0);
      add(K_SAMPLE, 0, 0, 32'h1234_ABCD, 0, 3, 64'h1234_ABCD, 0);
      add(K_SAMPLE, 1, 0, 32'h8000_7FFF, 0, 4, 64'h8000_7FFF, 0);
      add(K_SAMPLE, 1, 0, 32'h8000_7FFF, 0, 5, 64'h8000_7FFF, 0);
      // swap on channel 1, negate Q on channel 3, banks untouched
      add(K_WRITE, 0, FE + 16, 32'h1, 0, 6, 64'hA5A5_0001, 0);
      add(K_WRITE, 1, FE + 16, 32'h2, 0, 8, 64'h1234_5678, 0);
      add(K_SAMPLE, 0, 0, 32'h1234_ABCD, 0, 2, 64'h1234_ABCD, 0);
      add(K_SAMPLE, 0, 0, 32'h1234_ABCD, 0, 3, 64'hABCD_1234, 0);
      add(K_SAMPLE, 1, 0, 32'h0100_0005, 0, 4, 64'h0100_0005, 0);
      add(K_SAMPLE, 1, 0, 32'h0100_0005, 0, 5, 64'h0100_FFFB, 0);
      add(K_SAMPLE, 1, 0, 32'h7000_8000, 0, 4, 64'h7000_8000, 0);
      add(K_SAMPLE, 1, 0, 32'h7000_8000, 0, 5, 64'h7000_7FFF, 0);
      // back to back
      add(K_PAIR, 0, 0, 32'h0001_0002, 32'h0003_0004, 3, 64'h0002_0001, 64'h0004_0003);
      add(K_PAIR, 1, 0, 32'h0010_0001, 32'h0020_8000, 5, 64'h0010_FFFF, 64'h0020_7FFF);

      repeat (5) @(negedge radio_clk);
      i_reset = 1'b0;
      for (int e = 0; e < n_entries; e++)
         apply_entry(e);
      @(negedge radio_clk);

      $display("tests %0d, passed %0d, failed %0d, timeouts %0d",
               pass_count + fail_count, pass_count, fail_count, timeouts);
      if (fail_count == 0 && timeouts == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: vlog.f
+incdir+logic
logic/settings_bus_pkg.sv
logic/sample_pkg.sv
logic/db_control.sv
logic/rx_frontend.sv
logic/x300_radio_core.sv
verification/radio_checker.sv
verification/radio_core_props.sv
verification/tb_x300_radio_core.sv

// File: Bender.yml
package:
  name: x300_radio_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/settings_bus_pkg.sv
      - logic/sample_pkg.sv
      - logic/db_control.sv
      - logic/rx_frontend.sv
      - logic/x300_radio_core.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/radio_checker.sv
      - verification/radio_core_props.sv
      - verification/tb_x300_radio_core.sv
